// ==== dv/tb_clock.sv ====
// Free running clock and power-on reset for the testbench
module tb_clock #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;                      // Released off the edge
   end

endmodule

// ==== dv/tb_packet_gen.sv ====
module tb_packet_gen;

   localparam int LEN_WIDTH  = 14;
   localparam int STOP_AFTER = 3;          // Packets let through in the stop run

   logic        clk, reset, write, read;
   logic        tx_ready, tx_valid, tx_sop, tx_eop;
   logic [7:0]  address;
   logic [31:0] writedata, readdata;
   logic [63:0] tx_data;
   logic [2:0]  tx_empty;

   integer      seed = 32'hf6a6;
   logic [68:0] exp_q [$];                 // {sop, eop, empty, data} per beat
   logic [69:0] held;                      // Outputs seen at the last monitor sample
   logic        stalled = 1'b0;
   int          sop_count = 0;
   int          exp_pkts = 0;              // Packets the model expects in this run
   int          cycles = 0;
   int          cycle_limit = 200;         // Reset and register phase

   tb_clock clock_gen (.clk(clk), .reset(reset));
   packet_gen_top #(.LEN_WIDTH(LEN_WIDTH)) UUT (.*);

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   // ---------------------------------------------------------------------------
   // Register bus tasks called one unit after a rising edge
   // ---------------------------------------------------------------------------
   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      address   = addr;
      writedata = data;
      write     = 1'b1;
      @(posedge clk);
      #1 write = 1'b0;
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
      address = addr;
      read    = 1'b1;
      @(posedge clk);
      #1 read = 1'b0;                      // Readdata was registered on that edge
      assert (readdata == expected)
         else abort_run($sformatf("error readdata at %h: got %h expected %h",
                                  addr, readdata, expected));
   endtask

   // Program a run, queue the expected beats, then pulse start
   task automatic start_run(input int n_cfg, input int n_exp, input int len);
      logic [63:0] da;
      logic [63:0] sa;
      logic [63:0] word;
      int          nb;
      da = {$random(seed), $random(seed)};
      sa = {$random(seed), $random(seed)};
      bus_write(gen_regs_pkg::mac_da0, da[31:0]);
      bus_write(gen_regs_pkg::mac_da1, {16'h0, da[47:32]});
      bus_write(gen_regs_pkg::mac_sa0, sa[31:0]);
      bus_write(gen_regs_pkg::mac_sa1, {16'h0, sa[47:32]});
      bus_write(gen_regs_pkg::num_packets, n_cfg);
      bus_write(gen_regs_pkg::pkt_length, len);
      nb = (len + 7) / 8;
      for (int p = 0; p < n_exp; p++) begin
         exp_q.push_back({2'b10, 3'd0, da[47:0], sa[47:32]});
         exp_q.push_back({1'b0, len == 0, 3'd0, sa[31:0], 16'(len), 16'(p)});
         for (int b = 0; b < nb; b++) begin
            for (int j = 0; j < 8; j++) begin
               word[63 - 8*j -: 8] = 8'(8*b + j);     // Byte index mod 256 with byte 0 in MSB
            end
            exp_q.push_back({1'b0, b == nb - 1,
                             (b == nb - 1) ? 3'((8 - len % 8) % 8) : 3'd0, word});
         end
      end
      cycle_limit = cycle_limit + 4 * n_exp * (nb + 2) + 200;
      sop_count = 0;
      exp_pkts  = n_exp;
      bus_write(gen_regs_pkg::start, 32'd1);
   endtask

   // Take every expected beat, then watch for strays and read the count back
   task automatic finish_run(input bit stall);
      while (exp_q.size() != 0) begin
         tx_ready = stall ? ($unsigned($random(seed)) % 10 >= 4) : 1'b1;  // ~40% low
         @(posedge clk);
         #1;
      end
      tx_ready = 1'b1;
      repeat (20) @(posedge clk);          // No beat may show up in this quiet window
      #1;
      check_reg(gen_regs_pkg::tx_pkt_count, exp_pkts);
   endtask

   // ---------------------------------------------------------------------------
   // Stream monitor sampled mid cycle where everything is settled
   // ---------------------------------------------------------------------------
   always @(negedge clk) begin
      logic [68:0] want;
      logic [63:0] mask;
      if (!reset) begin
         if (stalled) begin
            assert ({tx_valid, tx_sop, tx_eop, tx_empty, tx_data} == held)
               else abort_run($sformatf("error tx outputs under stall: got %h expected %h",
                                        {tx_valid, tx_sop, tx_eop, tx_empty, tx_data}, held));
         end
         stalled = tx_valid && !tx_ready;
         held    = {tx_valid, tx_sop, tx_eop, tx_empty, tx_data};
         if (tx_valid && tx_ready) begin
            assert (exp_q.size() != 0) else abort_run("Beat accepted while none was expected");
            want = exp_q.pop_front();
            mask = {64{1'b1}} << (8 * want[66:64]);   // Unused lanes at the low end
            assert ({tx_sop, tx_eop} == want[68:67])
               else abort_run($sformatf("error tx_sop/tx_eop: got %h expected %h",
                                        {tx_sop, tx_eop}, want[68:67]));
            assert (!tx_eop || tx_empty == want[66:64])
               else abort_run($sformatf("error tx_empty: got %h expected %h",
                                        tx_empty, want[66:64]));
            assert ((tx_data & mask) == (want[63:0] & mask))
               else abort_run($sformatf("error tx_data: got %h expected %h",
                                        tx_data, want[63:0]));
            if (tx_sop) sop_count++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) abort_run($sformatf("Timeout after %0d cycles", cycles));
   end

   // ---------------------------------------------------------------------------
   // Test sequence
   // ---------------------------------------------------------------------------
   initial begin
      logic [7:0]  regs [7];
      logic [31:0] masks [7];
      logic [31:0] vals [7];
      logic [7:0]  unmapped [8];
      int          n;
      address   = '0;
      write     = 1'b0;
      read      = 1'b0;
      writedata = '0;
      tx_ready  = 1'b0;
      regs  = '{gen_regs_pkg::num_packets, gen_regs_pkg::stop, gen_regs_pkg::mac_sa0,
                gen_regs_pkg::mac_sa1, gen_regs_pkg::mac_da0, gen_regs_pkg::mac_da1,
                gen_regs_pkg::pkt_length};
      masks = '{32'hffff_ffff, 32'h1, 32'hffff_ffff, 32'hffff, 32'hffff_ffff, 32'hffff,
                (32'd1 << LEN_WIDTH) - 32'd1};
      // Start strobe reads as zero like the holes
      unmapped = '{8'h01, 8'h02, 8'h03, 8'h0a, 8'h0b, 8'h0c, 8'h0e,
                   8'h10 + 8'($unsigned($random(seed)) % 240)};
      @(negedge reset);
      @(posedge clk);
      #1 tx_ready = 1'b1;
      for (int i = 0; i < 7; i++) begin
         vals[i] = $random(seed);
         bus_write(regs[i], vals[i]);
      end
      for (int i = 0; i < 7; i++) check_reg(regs[i], vals[i] & masks[i]);
      for (int i = 0; i < 8; i++) check_reg(unmapped[i], 32'd0);
      check_reg(gen_regs_pkg::tx_pkt_count, 32'd0);
      bus_write(gen_regs_pkg::stop, 32'd0);

      start_run(2, 2, 0);                  // Header only packets
      finish_run(1'b0);
      for (int r = 0; r < 6; r++) begin
         n = 1 + $unsigned($random(seed)) % 4;
         start_run(n, n, $unsigned($random(seed)) % 301);
         finish_run(r >= 3);               // Back-pressure in the later runs
      end

      // Long packets where stop lands inside packet STOP_AFTER
      start_run(20, STOP_AFTER, 200 + $unsigned($random(seed)) % 101);
      while (sop_count < STOP_AFTER) begin
         @(posedge clk);
         #1;
      end
      bus_write(gen_regs_pkg::stop, 32'd1);
      finish_run(1'b0);
      bus_write(gen_regs_pkg::stop, 32'd0);

      $display("TEST OK");
      $finish;
   end

endmodule

// ==== logic/beat_if.sv ====
// One beat descriptor, sequencer to word former
interface beat_if ();

   logic                                    valid;
   gen_stream_pkg::beat_kind_e              kind;
   logic                                    sop;
   logic                                    eop;
   logic [gen_stream_pkg::EMPTY_WIDTH-1:0]  empty;
   logic [gen_stream_pkg::SEQ_WIDTH-1:0]    seq;
   logic [15:0]                             length;     // Header length field
   logic                                    pat_reset;  // Restart payload pattern

   modport src (output valid, kind, sop, eop, empty, seq, length, pat_reset);
   modport dst (input  valid, kind, sop, eop, empty, seq, length, pat_reset);

endinterface

// ==== logic/frame_sequencer.sv ====
module frame_sequencer #(
   parameter int LEN_WIDTH = 14
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      tx_ready,
   gen_cfg_if.seq    cfg,
   beat_if.src       beat
);

   localparam int EW = gen_stream_pkg::EMPTY_WIDTH;

   // Bytes consumed per payload beat, at counter width
   localparam logic [LEN_WIDTH-1:0] BEAT_BYTES = LEN_WIDTH'(gen_stream_pkg::BYTES_PER_BEAT);

   gen_stream_pkg::seq_state_e            state;
   logic [LEN_WIDTH-1:0]                  len_q;       // Length latched per packet
   logic [LEN_WIDTH-1:0]                  remaining;   // Payload bytes still to send
   logic [gen_stream_pkg::SEQ_WIDTH-1:0]  seq_num;
   logic [EW-1:0]                         last_empty;
   logic                                  last_beat;

   // (8 - len mod 8) mod 8 is just the negated low bits
   assign last_empty = ~len_q[EW-1:0] + 1'b1;

   // Zero payload ends on the second header beat
   assign last_beat = ((state == gen_stream_pkg::src_len_seq) && (len_q == '0)) ||
                      ((state == gen_stream_pkg::data) && (remaining <= BEAT_BYTES));

   // -------------------------------------------------------------------------
   // Frame FSM and registered beat descriptor
   // -------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state          <= gen_stream_pkg::idle;
         len_q          <= '0;
         remaining      <= '0;
         seq_num        <= '0;
         cfg.pkt_count  <= '0;
         beat.valid     <= 1'b0;
         beat.kind      <= gen_stream_pkg::hdr_addr;
         beat.sop       <= 1'b0;
         beat.eop       <= 1'b0;
         beat.empty     <= '0;
         beat.seq       <= '0;
         beat.length    <= '0;
         beat.pat_reset <= 1'b0;
      end else if (state == gen_stream_pkg::idle) begin
         // Start is a single pulse, take it whatever tx_ready does
         if (cfg.start && (cfg.num_packets != '0)) begin
            state         <= gen_stream_pkg::dest_src;
            seq_num       <= '0;
            cfg.pkt_count <= '0;              // New run counts from zero
         end
      end else if (tx_ready) begin
         beat.valid     <= 1'b1;
         beat.sop       <= 1'b0;
         beat.eop       <= last_beat;
         beat.empty     <= last_beat ? last_empty : '0;
         beat.pat_reset <= 1'b0;
         case (state)
            gen_stream_pkg::dest_src: begin
               beat.kind      <= gen_stream_pkg::hdr_addr;
               beat.sop       <= 1'b1;
               beat.pat_reset <= 1'b1;         // Former rewinds before payload
               len_q          <= cfg.pkt_length;
               remaining      <= cfg.pkt_length;
               state          <= gen_stream_pkg::src_len_seq;
            end
            gen_stream_pkg::src_len_seq: begin
               beat.kind   <= gen_stream_pkg::hdr_len_seq;
               beat.length <= 16'(len_q);
               beat.seq    <= seq_num;
               state       <= (len_q == '0) ? gen_stream_pkg::gap : gen_stream_pkg::data;
            end
            gen_stream_pkg::data: begin
               beat.kind <= gen_stream_pkg::payload;
               remaining <= remaining - BEAT_BYTES;
               if (last_beat) begin
                  state <= gen_stream_pkg::gap;
               end
            end
            default: begin                    // Gap, one empty slot
               beat.valid <= 1'b0;
               if (cfg.stop || (cfg.pkt_count >= cfg.num_packets)) begin
                  state <= gen_stream_pkg::idle;
               end else begin
                  state <= gen_stream_pkg::dest_src;
               end
            end
         endcase
         // Packet done once its eop beat is issued
         if (last_beat) begin
            seq_num       <= seq_num + 1'b1;
            cfg.pkt_count <= cfg.pkt_count + 1'b1;
         end
      end
   end

endmodule

// ==== logic/gen_cfg_if.sv ====
// Configuration from the register block, status back from the sequencer
interface gen_cfg_if #(
   parameter int LEN_WIDTH = 14
) ();

   logic [gen_regs_pkg::MAC_WIDTH-1:0] mac_da;       // Destination MAC
   logic [gen_regs_pkg::MAC_WIDTH-1:0] mac_sa;       // Source MAC
   logic [gen_regs_pkg::REG_WIDTH-1:0] num_packets;  // Packets per run
   logic [LEN_WIDTH-1:0]               pkt_length;   // Payload bytes
   logic                               start;        // One cycle pulse
   logic                               stop;         // Level
   logic [gen_regs_pkg::REG_WIDTH-1:0] pkt_count;    // Finished packets

   // Register block side
   modport csr (output mac_da, mac_sa, num_packets, pkt_length, start, stop,
                input  pkt_count);

   // Frame sequencer side
   modport seq (input  num_packets, pkt_length, start, stop,
                output pkt_count);

   // Word former only needs the addresses
   modport frm (input mac_da, mac_sa);

endinterface

// ==== logic/gen_csr.sv ====
module gen_csr #(
   parameter int LEN_WIDTH = 14
) (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [7:0]                           address,
   input  logic                                 write,
   input  logic                                 read,
   input  logic [gen_regs_pkg::REG_WIDTH-1:0]   writedata,
   output logic [gen_regs_pkg::REG_WIDTH-1:0]   readdata,
   gen_cfg_if.csr                               cfg
);

   localparam int RW = gen_regs_pkg::REG_WIDTH;
   localparam int MW = gen_regs_pkg::MAC_WIDTH;

   // -------------------------------------------------------------------------
   // Writable registers, a write lands on the next edge
   // -------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg.num_packets <= '0;
         cfg.pkt_length  <= '0;
         cfg.stop        <= 1'b0;
         cfg.mac_sa      <= '0;
         cfg.mac_da      <= '0;
      end else if (write) begin
         case (address)
            gen_regs_pkg::num_packets: cfg.num_packets <= writedata;
            gen_regs_pkg::stop:        cfg.stop <= writedata[0];
            gen_regs_pkg::mac_sa0:     cfg.mac_sa[RW-1:0] <= writedata;
            gen_regs_pkg::mac_sa1:     cfg.mac_sa[MW-1:RW] <= writedata[MW-RW-1:0];
            gen_regs_pkg::mac_da0:     cfg.mac_da[RW-1:0] <= writedata;
            gen_regs_pkg::mac_da1:     cfg.mac_da[MW-1:RW] <= writedata[MW-RW-1:0];
            gen_regs_pkg::pkt_length:  cfg.pkt_length <= writedata[LEN_WIDTH-1:0];
            default: ;                 // Read only or unmapped
         endcase
      end
   end

   // Start is not stored, a write of 1 gives one pulse the cycle after
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg.start <= 1'b0;
      end else begin
         cfg.start <= write && (address == gen_regs_pkg::start) && writedata[0];
      end
   end

   // -------------------------------------------------------------------------
   // Read mux, data valid one cycle after the read strobe
   // -------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            gen_regs_pkg::num_packets:  readdata <= cfg.num_packets;
            gen_regs_pkg::stop:         readdata <= RW'(cfg.stop);
            gen_regs_pkg::mac_sa0:      readdata <= cfg.mac_sa[RW-1:0];
            gen_regs_pkg::mac_sa1:      readdata <= RW'(cfg.mac_sa[MW-1:RW]);
            gen_regs_pkg::mac_da0:      readdata <= cfg.mac_da[RW-1:0];
            gen_regs_pkg::mac_da1:      readdata <= RW'(cfg.mac_da[MW-1:RW]);
            gen_regs_pkg::tx_pkt_count: readdata <= cfg.pkt_count;  // Live count
            gen_regs_pkg::pkt_length:   readdata <= RW'(cfg.pkt_length);
            default:                    readdata <= '0;  // Start reads as zero too
         endcase
      end
   end

endmodule

// ==== logic/gen_regs_pkg.sv ====
// -------------------------------------------------------------------------
// Register map of the packet generator
// -------------------------------------------------------------------------
package gen_regs_pkg;

   // Byte addresses on the register bus
   typedef enum logic [7:0] {
      num_packets  = 8'h00,     // Packets per run
      start        = 8'h03,     // Write 1 to launch a run
      stop         = 8'h04,     // Level, ends the run at a packet boundary
      mac_sa0      = 8'h05,     // Source MAC [31:0]
      mac_sa1      = 8'h06,     // Source MAC [47:32]
      mac_da0      = 8'h07,     // Destination MAC [31:0]
      mac_da1      = 8'h08,     // Destination MAC [47:32]
      tx_pkt_count = 8'h09,     // Packets sent in the current run, read only
      pkt_length   = 8'h0d      // Payload byte count
   } reg_addr_e;

   localparam int REG_WIDTH = 32;   // Bus data width
   localparam int MAC_WIDTH = 48;   // One MAC address

endpackage

// ==== logic/gen_stream_pkg.sv ====
// -------------------------------------------------------------------------
// Stream side definitions shared by the pipeline stages
// -------------------------------------------------------------------------
package gen_stream_pkg;

   localparam int BEAT_WIDTH     = 64;  // Stream data width
   localparam int EMPTY_WIDTH    = 3;   // Unused byte count on the eop beat
   localparam int BYTES_PER_BEAT = 8;
   localparam int SEQ_WIDTH      = 16;  // Per packet sequence number

   // What the word former puts on the data bus
   typedef enum logic [1:0] {
      hdr_addr,      // DA and upper SA
      hdr_len_seq,   // Lower SA, length, sequence number
      payload        // Incrementing byte pattern
   } beat_kind_e;

   // Frame sequencer states
   typedef enum logic [2:0] {
      idle,
      dest_src,
      src_len_seq,
      data,
      gap            // One idle beat between packets
   } seq_state_e;

   // First payload word, byte 00 sits in the most significant lane
   localparam logic [BEAT_WIDTH-1:0] PATTERN_FIRST = 64'h0001_0203_0405_0607;

   // Added lane by lane for each following word, each lane wraps on its own
   localparam logic [BEAT_WIDTH-1:0] PATTERN_STEP  = 64'h0808_0808_0808_0808;

endpackage

// ==== logic/packet_gen_top.sv ====
module packet_gen_top #(
   parameter int LEN_WIDTH = 14     // Payload byte count width
) (
   input  logic                                     clk,
   input  logic                                     reset,
   // Register bus
   input  logic [7:0]                               address,
   input  logic                                     write,
   input  logic                                     read,
   input  logic [gen_regs_pkg::REG_WIDTH-1:0]       writedata,
   output logic [gen_regs_pkg::REG_WIDTH-1:0]       readdata,
   // Transmit stream
   input  logic                                     tx_ready,
   output logic [gen_stream_pkg::BEAT_WIDTH-1:0]    tx_data,
   output logic                                     tx_valid,
   output logic                                     tx_sop,
   output logic                                     tx_eop,
   output logic [gen_stream_pkg::EMPTY_WIDTH-1:0]   tx_empty
);

   gen_cfg_if #(.LEN_WIDTH(LEN_WIDTH)) cfg_bus ();
   beat_if                             beat_bus ();

   gen_csr #(.LEN_WIDTH(LEN_WIDTH)) u_csr (
      .clk       (clk),
      .reset     (reset),
      .address   (address),
      .write     (write),
      .read      (read),
      .writedata (writedata),
      .readdata  (readdata),
      .cfg       (cfg_bus.csr)
   );

   // Stage 1, frame FSM
   frame_sequencer #(.LEN_WIDTH(LEN_WIDTH)) u_seq (
      .clk      (clk),
      .reset    (reset),
      .tx_ready (tx_ready),
      .cfg      (cfg_bus.seq),
      .beat     (beat_bus.src)
   );

   // Stage 2, data word and output registers
   word_former u_frm (
      .clk      (clk),
      .reset    (reset),
      .tx_ready (tx_ready),
      .beat     (beat_bus.dst),
      .cfg      (cfg_bus.frm),
      .tx_data  (tx_data),
      .tx_valid (tx_valid),
      .tx_sop   (tx_sop),
      .tx_eop   (tx_eop),
      .tx_empty (tx_empty)
   );

endmodule

// ==== logic/word_former.sv ====
module word_former (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     tx_ready,
   beat_if.dst                                      beat,
   gen_cfg_if.frm                                   cfg,
   output logic [gen_stream_pkg::BEAT_WIDTH-1:0]    tx_data,
   output logic                                     tx_valid,
   output logic                                     tx_sop,
   output logic                                     tx_eop,
   output logic [gen_stream_pkg::EMPTY_WIDTH-1:0]   tx_empty
);

   localparam int BW = gen_stream_pkg::BEAT_WIDTH;

   logic [BW-1:0] pattern;    // Current payload word
   logic [BW-1:0] pat_next;
   logic [BW-1:0] word;

   // Per lane add, no carry between bytes so FF wraps to 00
   always_comb begin
      for (int i = 0; i < gen_stream_pkg::BYTES_PER_BEAT; i++) begin
         pat_next[8*i +: 8] = pattern[8*i +: 8] + gen_stream_pkg::PATTERN_STEP[8*i +: 8];
      end
   end

   always_ff @(posedge clk) begin
      if (tx_ready && beat.valid) begin
         if (beat.pat_reset) begin
            pattern <= gen_stream_pkg::PATTERN_FIRST;
         end else if (beat.kind == gen_stream_pkg::payload) begin
            pattern <= pat_next;             // Step once per payload beat
         end
      end
   end

   // -------------------------------------------------------------------------
   // Data word by beat kind
   // -------------------------------------------------------------------------
   always_comb begin
      case (beat.kind)
         gen_stream_pkg::hdr_addr:    word = {cfg.mac_da, cfg.mac_sa[47:32]};
         gen_stream_pkg::hdr_len_seq: word = {cfg.mac_sa[31:0], beat.length, beat.seq};
         default:                     word = pattern;
      endcase
   end

   always_ff @(posedge clk) begin
      if (tx_ready) begin
         tx_data <= word;
      end
   end

   // Framing copied straight from the descriptor, held while not ready
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end else if (tx_ready) begin
         tx_valid <= beat.valid;
         tx_sop   <= beat.valid & beat.sop;
         tx_eop   <= beat.valid & beat.eop;
         tx_empty <= beat.empty;
      end
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the packet generator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_packet_gen -f src.f -o tb_packet_gen
./obj_dir/tb_packet_gen | tee sim.log
if grep -qx "TEST OK" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== src.f ====
logic/gen_regs_pkg.sv
logic/gen_stream_pkg.sv
logic/gen_cfg_if.sv
logic/beat_if.sv
logic/gen_csr.sv
logic/frame_sequencer.sv
logic/word_former.sv
logic/packet_gen_top.sv
dv/tb_clock.sv
dv/tb_packet_gen.sv
